// ==== huff_mem_macros.svh ====
`ifndef HUFF_MEM_MACROS_SVH
`define HUFF_MEM_MACROS_SVH

// SRAM geometry
`define MEM_WORDS 1024
`define MEM_AW 10

// region base word addresses
`define HIST_BASE 0
`define HTREE_BASE 256
`define CB_BASE 512

`define HIST_ENTRIES 256 // words zeroed by a clear

// flow control toward the word SRAM
`define MEM_CREDITS 2
`define CREDIT_W 2

`endif

// ==== huff_mem_pkg.sv ====
`include "huff_mem_macros.svh"

package huff_mem_pkg;

    typedef enum logic [1:0] {
        REG_HIST,
        REG_HTREE,
        REG_CB
    } region_e;

    typedef enum logic [1:0] {
        OP_READ,
        OP_WRITE,
        OP_CLEAR
    } op_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_DRAIN,
        S_DONE
    } seq_state_e;

    typedef struct packed {
        op_e          op;
        region_e      region;
        logic [7:0]   index;
        logic [127:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic               we;
        logic [`MEM_AW-1:0] addr;
        logic [31:0]        wdata;
        logic               last;
    } mem_beat_t;

    typedef struct packed {
        logic [127:0] rdata;
    } mem_rsp_t;

    // words per entry in each region
    function automatic logic [2:0] region_words(region_e region);
        case (region)
            REG_HTREE: return 3'd2;
            REG_CB:    return 3'd4;
            default:   return 3'd1;
        endcase
    endfunction

    function automatic logic [8:0] xfer_beats(op_e op, region_e region);
        if (op == OP_CLEAR) begin
            return 9'(`HIST_ENTRIES);
        end
        return {6'd0, region_words(region)};
    endfunction

endpackage

// ==== mem_seq_fsm.sv ====
module mem_seq_fsm (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid_i,
    input  huff_mem_pkg::mem_req_t   req_i,
    input  logic [8:0]               beats_issued_i,
    input  logic [8:0]               beats_returned_i,
    input  logic                     credit_ok_i,
    output logic                     req_ready_o,
    output logic                     issue_o,
    output logic                     start_o,
    output huff_mem_pkg::seq_state_e state_o,
    output huff_mem_pkg::mem_req_t   cur_req_o,
    output logic                     rsp_valid_o
);

    huff_mem_pkg::seq_state_e state_d;
    logic [8:0]               total;

    assign total = huff_mem_pkg::xfer_beats(cur_req_o.op, cur_req_o.region);

    assign req_ready_o = (state_o == huff_mem_pkg::S_IDLE);
    assign start_o     = req_valid_i && req_ready_o;
    assign issue_o     = (state_o == huff_mem_pkg::S_ISSUE) && credit_ok_i;
    assign rsp_valid_o = (state_o == huff_mem_pkg::S_DONE);

    always_comb begin
        state_d = state_o;
        case (state_o)
            huff_mem_pkg::S_IDLE: begin
                if (start_o) begin
                    state_d = huff_mem_pkg::S_ISSUE;
                end
            end
            huff_mem_pkg::S_ISSUE: begin
                // leave once the final beat goes out
                if (issue_o && beats_issued_i == total - 9'd1) begin
                    state_d = huff_mem_pkg::S_DRAIN;
                end
            end
            huff_mem_pkg::S_DRAIN: begin
                if (beats_returned_i == beats_issued_i) begin
                    state_d = huff_mem_pkg::S_DONE;
                end
            end
            default: begin
                state_d = huff_mem_pkg::S_IDLE; // single cycle in done
            end
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state_o <= huff_mem_pkg::S_IDLE;
        end else begin
            state_o <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (start_o) begin
            cur_req_o <= req_i;
        end
    end

endmodule

// ==== beat_counter.sv ====
`include "huff_mem_macros.svh"

module beat_counter (
    input  logic       clk,
    input  logic       rst,
    input  logic       start_i,
    input  logic       issue_i,
    input  logic       ret_valid_i,
    output logic [8:0] beats_issued_o,
    output logic [8:0] beats_returned_o,
    output logic       credit_ok_o
);

    logic [`CREDIT_W-1:0] credit;

    // a word coming back this cycle frees its slot for the next issue
    assign credit_ok_o = (credit != '0) || ret_valid_i;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            beats_issued_o   <= '0;
            beats_returned_o <= '0;
        end else if (start_i) begin
            beats_issued_o   <= '0;
            beats_returned_o <= '0;
        end else begin
            if (issue_i) begin
                beats_issued_o <= beats_issued_o + 9'd1;
            end
            if (ret_valid_i) begin
                beats_returned_o <= beats_returned_o + 9'd1;
            end
        end
    end

    // credits persist across transfers
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            credit <= `CREDIT_W'(`MEM_CREDITS);
        end else begin
            case ({issue_i, ret_valid_i})
                2'b10:   credit <= credit - `CREDIT_W'(1);
                2'b01:   credit <= credit + `CREDIT_W'(1);
                default: credit <= credit;
            endcase
        end
    end

endmodule

// ==== addr_gen.sv ====
`include "huff_mem_macros.svh"

module addr_gen (
    input  huff_mem_pkg::mem_req_t  req_i,
    input  logic [8:0]              beat_i,
    output huff_mem_pkg::mem_beat_t beat_o
);

    logic [2:0]         words;
    logic [8:0]         total;
    logic [1:0]         slot;
    logic [`MEM_AW-1:0] base;
    logic [`MEM_AW-1:0] entry;

    assign words = huff_mem_pkg::region_words(req_i.region);
    assign total = huff_mem_pkg::xfer_beats(req_i.op, req_i.region);
    assign slot  = 2'(words - 3'd1 - {1'b0, beat_i[1:0]}); // first beat is the top word

    always_comb begin
        case (req_i.region)
            huff_mem_pkg::REG_HTREE: base = `MEM_AW'(`HTREE_BASE);
            huff_mem_pkg::REG_CB:    base = `MEM_AW'(`CB_BASE);
            default:                 base = `MEM_AW'(`HIST_BASE);
        endcase
        // tree and codebook hold 128 entries
        if (req_i.region == huff_mem_pkg::REG_HIST) begin
            entry = `MEM_AW'(req_i.index);
        end else begin
            entry = `MEM_AW'(req_i.index[6:0]);
        end
    end

    always_comb begin
        beat_o.we   = (req_i.op != huff_mem_pkg::OP_READ);
        beat_o.last = (beat_i == total - 9'd1);
        if (req_i.op == huff_mem_pkg::OP_CLEAR) begin
            beat_o.addr  = `MEM_AW'(`HIST_BASE) + `MEM_AW'(beat_i);
            beat_o.wdata = '0;
        end else begin
            beat_o.addr  = base + entry * `MEM_AW'(words) + `MEM_AW'(beat_i);
            beat_o.wdata = req_i.wdata[32*slot +: 32];
        end
    end

endmodule

// ==== rsp_assembler.sv ====
module rsp_assembler (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  huff_mem_pkg::region_e  region_i,
    input  logic                   ret_valid_i,
    input  logic [31:0]            ret_data_i,
    output huff_mem_pkg::mem_rsp_t rsp_o
);

    logic [1:0] ret_cnt;
    logic [2:0] words;
    logic [1:0] slot;

    assign words = huff_mem_pkg::region_words(region_i);
    assign slot  = 2'(words - 3'd1 - {1'b0, ret_cnt});

    // position of the next returned word, wraps on long clears
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ret_cnt <= '0;
        end else if (start_i) begin
            ret_cnt <= '0;
        end else if (ret_valid_i) begin
            ret_cnt <= ret_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            rsp_o.rdata <= '0;
        end else if (ret_valid_i) begin
            rsp_o.rdata[32*slot +: 32] <= ret_data_i; // write beats return zero
        end
    end

endmodule

// ==== word_sram.sv ====
`include "huff_mem_macros.svh"

module word_sram (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    beat_valid_i,
    input  huff_mem_pkg::mem_beat_t beat_i,
    output logic                    ret_valid_o,
    output logic [31:0]             ret_data_o
);

    logic [31:0]             mem [`MEM_WORDS];
    logic                    acc_valid;
    huff_mem_pkg::mem_beat_t acc_beat;

    // two stage valid pipe, one return per accepted beat
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            acc_valid   <= 1'b0;
            ret_valid_o <= 1'b0;
        end else begin
            acc_valid   <= beat_valid_i;
            ret_valid_o <= acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid_i) begin
            acc_beat <= beat_i;
        end
    end

    // array access in the second stage
    always_ff @(posedge clk) begin
        if (acc_valid) begin
            if (acc_beat.we) begin
                mem[acc_beat.addr] <= acc_beat.wdata;
                ret_data_o         <= '0;
            end else begin
                ret_data_o <= mem[acc_beat.addr];
            end
        end
    end

endmodule

// ==== huff_mem_top.sv ====
module huff_mem_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid_i,
    input  huff_mem_pkg::mem_req_t req_i,
    output logic                   req_ready_o,
    output logic                   rsp_valid_o,
    output huff_mem_pkg::mem_rsp_t rsp_o
);

    huff_mem_pkg::mem_req_t  cur_req;
    huff_mem_pkg::mem_beat_t beat;
    logic                    issue;
    logic                    start;
    logic                    credit_ok;
    logic [8:0]              beats_issued;
    logic [8:0]              beats_returned;
    logic                    ret_valid;
    logic [31:0]             ret_data;

    mem_seq_fsm mem_seq_fsm_i (
        .clk              (clk),
        .rst              (rst),
        .req_valid_i      (req_valid_i),
        .req_i            (req_i),
        .beats_issued_i   (beats_issued),
        .beats_returned_i (beats_returned),
        .credit_ok_i      (credit_ok),
        .req_ready_o      (req_ready_o),
        .issue_o          (issue),
        .start_o          (start),
        .state_o          (),
        .cur_req_o        (cur_req),
        .rsp_valid_o      (rsp_valid_o)
    );

    beat_counter beat_counter_i (
        .clk              (clk),
        .rst              (rst),
        .start_i          (start),
        .issue_i          (issue),
        .ret_valid_i      (ret_valid),
        .beats_issued_o   (beats_issued),
        .beats_returned_o (beats_returned),
        .credit_ok_o      (credit_ok)
    );

    addr_gen addr_gen_i (
        .req_i  (cur_req),
        .beat_i (beats_issued), // issued count is the next beat number
        .beat_o (beat)
    );

    word_sram word_sram_i (
        .clk          (clk),
        .rst          (rst),
        .beat_valid_i (issue),
        .beat_i       (beat),
        .ret_valid_o  (ret_valid),
        .ret_data_o   (ret_data)
    );

    rsp_assembler rsp_assembler_i (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start),
        .region_i    (cur_req.region),
        .ret_valid_i (ret_valid),
        .ret_data_i  (ret_data),
        .rsp_o       (rsp_o)
    );

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o; // period of 4
    end

endmodule

// ==== huff_mem_tb.sv ====
`include "huff_mem_macros.svh"

module huff_mem_tb;

    localparam int MAX_TESTS = 200;

    logic                   clk;
    logic                   rst;
    logic                   req_valid_i;
    logic                   req_ready_o;
    logic                   rsp_valid_o;
    huff_mem_pkg::mem_req_t req_i;
    huff_mem_pkg::mem_rsp_t rsp_o;

    logic [31:0]  model [`MEM_WORDS]; // reference copy of the SRAM
    logic [127:0] exp_q [$];
    string        name_q [$];
    string        cur_test;
    int           sent;
    int           rsp_count;
    logic         busy;
    int           seed;

    tb_clock_gen clock_gen_i (.clk_o(clk));

    huff_mem_top huff_mem_top_i (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    function automatic int words_of(huff_mem_pkg::region_e region);
        case (region)
            huff_mem_pkg::REG_HTREE: return 2;
            huff_mem_pkg::REG_CB:    return 4;
            default:                 return 1;
        endcase
    endfunction

    function automatic int word_addr(huff_mem_pkg::region_e region, logic [7:0] index, int beat);
        int base;
        int entry;
        case (region)
            huff_mem_pkg::REG_HTREE: base = `HTREE_BASE;
            huff_mem_pkg::REG_CB:    base = `CB_BASE;
            default:                 base = `HIST_BASE;
        endcase
        entry = (region == huff_mem_pkg::REG_HIST) ? index : index[6:0]; // 128 tree/cb entries
        return base + entry * words_of(region) + beat;
    endfunction

    // expected rdata with the first word in the top slot of the used width
    function automatic logic [127:0] expected_rdata(huff_mem_pkg::op_e op,
                                                    huff_mem_pkg::region_e region,
                                                    logic [7:0] index);
        logic [127:0] r;
        int           w;
        int           b;
        r = '0;
        w = words_of(region);
        if (op == huff_mem_pkg::OP_READ) begin
            for (b = 0; b < w; b++) begin
                r[32*(w-1-b) +: 32] = model[word_addr(region, index, b)];
            end
        end
        return r;
    endfunction

    function automatic logic [127:0] rand128();
        return {$urandom, $urandom, $urandom, $urandom};
    endfunction

    task automatic send(input huff_mem_pkg::op_e op, input huff_mem_pkg::region_e region,
                        input logic [7:0] index, input logic [127:0] wdata);
        int w;
        int b;
        w = words_of(region);
        exp_q.push_back(expected_rdata(op, region, index));
        name_q.push_back(cur_test);
        if (op == huff_mem_pkg::OP_WRITE) begin
            for (b = 0; b < w; b++) begin
                model[word_addr(region, index, b)] = wdata[32*(w-1-b) +: 32];
            end
        end else if (op == huff_mem_pkg::OP_CLEAR) begin
            for (b = 0; b < `HIST_ENTRIES; b++) begin
                model[`HIST_BASE + b] = '0;
            end
        end
        req_i       <= '{op: op, region: region, index: index, wdata: wdata};
        req_valid_i <= 1'b1;
        do @(posedge clk); while (!req_ready_o);
        req_valid_i <= 1'b0;
        sent++;
        do @(posedge clk); while (!rsp_valid_o);
    endtask

    // compare on each response and check ready stays low while busy
    always @(posedge clk) begin
        logic [127:0] exp;
        string        name;
        if (!rst) begin
            if (rsp_valid_o) begin
                assert (busy) else report_failure("response arrived without a request");
                exp  = exp_q.pop_front();
                name = name_q.pop_front();
                assert (rsp_o.rdata === exp) else report_failure($sformatf(
                    "MISMATCH %s expected %h actual %h", name, exp, rsp_o.rdata));
                busy = 1'b0;
                rsp_count++;
            end else if (busy) begin
                assert (!req_ready_o)
                    else report_failure("req_ready_o went high during a request");
            end
            if (req_valid_i && req_ready_o) begin
                busy = 1'b1;
            end
        end
    end

    initial begin
        #(MAX_TESTS * (256 + 10) * 4);
        report_failure("run timed out before all tests finished");
    end

    initial begin
        logic [7:0] idx;
        int         i;
        seed        = 32'h7c96;
        void'($urandom(seed));
        rst         = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        busy        = 1'b0;
        sent        = 0;
        rsp_count   = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        cur_test = "clear_then_read";
        send(huff_mem_pkg::OP_CLEAR, huff_mem_pkg::REG_HIST, 8'd0, '0);
        repeat (20) send(huff_mem_pkg::OP_READ, huff_mem_pkg::REG_HIST, 8'($urandom), '0);

        cur_test = "hist_write_read";
        for (i = 0; i < 4; i++) begin
            idx = 8'($urandom);
            send(huff_mem_pkg::OP_WRITE, huff_mem_pkg::REG_HIST, idx, rand128());
            send(huff_mem_pkg::OP_READ, huff_mem_pkg::REG_HIST, idx, '0);
        end

        cur_test = "tree_node";
        send(huff_mem_pkg::OP_WRITE, huff_mem_pkg::REG_HTREE, 8'd40, rand128());
        send(huff_mem_pkg::OP_WRITE, huff_mem_pkg::REG_HTREE, 8'd39, rand128());
        send(huff_mem_pkg::OP_WRITE, huff_mem_pkg::REG_HTREE, 8'd41, rand128());
        send(huff_mem_pkg::OP_READ, huff_mem_pkg::REG_HTREE, 8'd40, '0);
        send(huff_mem_pkg::OP_READ, huff_mem_pkg::REG_HTREE, 8'd39, '0);

        cur_test = "codebook";
        send(huff_mem_pkg::OP_WRITE, huff_mem_pkg::REG_CB, 8'd77, rand128());
        send(huff_mem_pkg::OP_CLEAR, huff_mem_pkg::REG_CB, 8'd0, '0);
        send(huff_mem_pkg::OP_READ, huff_mem_pkg::REG_CB, 8'd77, '0);
        send(huff_mem_pkg::OP_READ, huff_mem_pkg::REG_HIST, 8'd77, '0);

        // known contents for the entries the random phase touches
        cur_test = "preload";
        for (i = 0; i < 8; i++) begin
            send(huff_mem_pkg::OP_WRITE, huff_mem_pkg::REG_HTREE, 8'(i), rand128());
            send(huff_mem_pkg::OP_WRITE, huff_mem_pkg::REG_CB, 8'(i), rand128());
        end

        cur_test = "random_ops";
        repeat (150) begin
            idx = 8'($urandom) & 8'h87; // bit 7 checks the 7-bit index wrap
            send(huff_mem_pkg::op_e'($urandom % 3), huff_mem_pkg::region_e'($urandom % 3),
                 idx, rand128());
        end

        @(posedge clk);
        assert (rsp_count == sent && exp_q.size() == 0) begin
            $display("No errors");
            $finish;
        end else begin
            report_failure("number of responses differs from accepted requests");
        end
    end

endmodule

// ==== all.f ====
+incdir+.
huff_mem_pkg.sv
mem_seq_fsm.sv
beat_counter.sv
addr_gen.sv
rsp_assembler.sv
word_sram.sv
huff_mem_top.sv
tb_clock_gen.sv
huff_mem_tb.sv
